// File: build.f
src/sd_ds_pkg.sv
src/sd_ds_afifo.sv
src/sd_ds_data_capture.sv
src/sd_ds_cmd_capture.sv
src/sd_ds_frontend.sv
testbench/tb_sd_ds_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilator build and run of the DS front end testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_sd_ds_frontend \
	-f build.f -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1

// File: src/sd_ds_afifo.sv
`timescale 1ns/10ps

// Dual clock FIFO, Gray pointers, first word fall through on read
module sd_ds_afifo #(
	parameter int LGFIFO = 4,
	parameter type payload_t = logic [7:0],
	parameter bit WRITE_ON_POSEDGE = 1'b1
) (
	// Write side, DS domain
	input  logic     i_wclk,
	input  logic     i_wr_reset_n,
	input  logic     i_wr,
	input  payload_t i_wr_data,
	output logic     o_wr_full,
	// Read side, system clock domain
	input  logic     i_rclk,
	input  logic     i_rd_reset_n,
	input  logic     i_rd,
	output payload_t o_rd_data,
	output logic     o_rd_empty
);

	localparam int DEPTH = 1 << LGFIFO;

	logic            wclk;
	logic            wr_go;
	logic            rd_go;
	payload_t        mem [0:DEPTH-1];
	logic [LGFIFO:0] wbin;
	logic [LGFIFO:0] wbin_next;
	logic [LGFIFO:0] wgray;
	logic [LGFIFO:0] wq1_rgray;
	logic [LGFIFO:0] wq2_rgray;
	logic [LGFIFO:0] rbin;
	logic [LGFIFO:0] rbin_next;
	logic [LGFIFO:0] rgray;
	logic [LGFIFO:0] rq1_wgray;
	logic [LGFIFO:0] rq2_wgray;

	// Falling edge lanes run the write side off the inverted strobe
	assign wclk = WRITE_ON_POSEDGE ? i_wclk : ~i_wclk;

	////////////////////////////////////////////////////////////////////////////
	//
	// Write side
	//
	////////////////////////////////////////////////////////////////////////////

	assign wr_go = i_wr && !o_wr_full;
	assign wbin_next = wbin + (LGFIFO+1)'(wr_go);

	// Full when top two Gray bits differ and the rest match
	assign o_wr_full = (wgray == {~wq2_rgray[LGFIFO:LGFIFO-1], wq2_rgray[LGFIFO-2:0]});

	always_ff @(posedge wclk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wbin <= '0;
			wgray <= '0;
			wq1_rgray <= '0;
			wq2_rgray <= '0;
		end
		else
		begin
			wbin <= wbin_next;
			wgray <= (wbin_next >> 1) ^ wbin_next;
			// Read pointer into write domain
			wq1_rgray <= rgray;
			wq2_rgray <= wq1_rgray;
		end
	end

	// Storage, no reset
	always_ff @(posedge wclk)
	begin
		if (wr_go)
			mem[wbin[LGFIFO-1:0]] <= i_wr_data;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Read side
	//
	////////////////////////////////////////////////////////////////////////////

	assign rd_go = i_rd && !o_rd_empty;
	assign rbin_next = rbin + (LGFIFO+1)'(rd_go);

	// Empty once the synced write pointer catches up
	assign o_rd_empty = (rgray == rq2_wgray);

	// Head entry shown without a read strobe
	assign o_rd_data = mem[rbin[LGFIFO-1:0]];

	always_ff @(posedge i_rclk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rbin <= '0;
			rgray <= '0;
			rq1_wgray <= '0;
			rq2_wgray <= '0;
		end
		else
		begin
			rbin <= rbin_next;
			rgray <= (rbin_next >> 1) ^ rbin_next;
			// Write pointer into read domain
			rq1_wgray <= wgray;
			rq2_wgray <= rq1_wgray;
		end
	end

	// Sender outran the reader, a sample would be lost
	a_no_overflow: assert property (@(posedge wclk) disable iff (!i_wr_reset_n)
		!(i_wr && o_wr_full));

	// Reader must wait for a synced entry
	a_no_underflow: assert property (@(posedge i_rclk) disable iff (!i_rd_reset_n)
		!(i_rd && o_rd_empty));

endmodule

// File: src/sd_ds_cmd_capture.sv
`timescale 1ns/10ps

// CMD capture on rising DS edges, bits handed out in pairs
module sd_ds_cmd_capture #(
	parameter int LGFIFO = 4
) (
	input  logic                 i_clk,
	input  logic                 i_afifo_reset_n,
	input  logic                 i_ds,
	input  logic                 i_cmd_en,
	input  logic                 i_cmd,
	output logic                 o_cmd_valid,
	output sd_ds_pkg::cmd_pair_t o_cmd_pair
);

	localparam int NLANES = sd_ds_pkg::CMD_PAIR_W;

	logic              cmd_reset_n;
	logic              started;
	logic              toggle;
	logic              cmd_take;
	logic [NLANES-1:0] lane_wr;
	logic [NLANES-1:0] lane_empty;
	logic              lane_data [0:NLANES-1];

	// Held clear while the host drives CMD
	assign cmd_reset_n = i_afifo_reset_n && !i_cmd_en;

	////////////////////////////////////////////////////////////////////////////
	//
	// Start tracking, DS domain
	//
	////////////////////////////////////////////////////////////////////////////

	// Start bit itself is kept
	assign cmd_take = started || !i_cmd;

	always_ff @(posedge i_ds or negedge cmd_reset_n)
	begin
		if (!cmd_reset_n)
		begin
			started <= 1'b0;
			toggle <= 1'b0;
		end
		else
		begin
			if (!i_cmd)
				started <= 1'b1;
			if (cmd_take)
				toggle <= ~toggle;
		end
	end

	// Start bit to lane 0, then 1, 0, 1
	assign lane_wr[0] = cmd_take && !toggle;
	assign lane_wr[1] = cmd_take && toggle;

	// Pair complete only when both lanes hold a bit
	assign o_cmd_valid = (lane_empty == '0);

	for (genvar gk = 0; gk < NLANES; gk++)
	begin : g_lane
		sd_ds_afifo #(
			.LGFIFO(LGFIFO),
			.payload_t(logic),
			.WRITE_ON_POSEDGE(1'b1)
		) u_lane_fifo (
			.i_wclk(i_ds),
			.i_wr_reset_n(cmd_reset_n),
			.i_wr(lane_wr[gk]),
			.i_wr_data(i_cmd),
			.o_wr_full(),
			.i_rclk(i_clk),
			.i_rd_reset_n(cmd_reset_n),
			.i_rd(o_cmd_valid),
			.o_rd_data(lane_data[gk]),
			.o_rd_empty(lane_empty[gk])
		);

		// Earlier bit in the MSB
		assign o_cmd_pair[NLANES-1-gk] = lane_data[gk];
	end

	// Lane 1 trails lane 0 by a full DS period
	a_pair_order: assert property (@(posedge i_clk) disable iff (!cmd_reset_n)
		!(!lane_empty[1] && lane_empty[0]));

endmodule

// File: src/sd_ds_data_capture.sv
`timescale 1ns/10ps

// DAT capture on both DS edges, four lanes packed into one word
module sd_ds_data_capture #(
	parameter int NUMIO = 8,
	parameter int LGFIFO = 4
) (
	input  logic                                      i_clk,
	input  logic                                      i_afifo_reset_n,
	input  logic                                      i_ds,
	input  logic [NUMIO-1:0]                          i_dat,
	output logic                                      o_data_valid,
	output logic [sd_ds_pkg::SAMPLES_PER_WORD*NUMIO-1:0] o_data_word
);

	localparam int NLANES = sd_ds_pkg::SAMPLES_PER_WORD;

	typedef logic [NUMIO-1:0] lane_t;

	logic              started_p;
	logic              count_p;
	logic              started_n;
	logic              count_n;
	logic [NLANES-1:0] lane_wr;
	logic [NLANES-1:0] lane_empty;
	lane_t             lane_data [0:NLANES-1];

	////////////////////////////////////////////////////////////////////////////
	//
	// Start tracking, DS domain
	//
	////////////////////////////////////////////////////////////////////////////

	// Rising edges, armed by the start bit on DAT0
	always_ff @(posedge i_ds or negedge i_afifo_reset_n)
	begin
		if (!i_afifo_reset_n)
		begin
			started_p <= 1'b0;
			count_p <= 1'b0;
		end
		else
		begin
			if (!i_dat[0])
				started_p <= 1'b1;
			// Lane 0 / lane 2 alternation
			if (started_p)
				count_p <= ~count_p;
		end
	end

	// Falling edges, armed half a cycle after the start bit
	always_ff @(negedge i_ds or negedge i_afifo_reset_n)
	begin
		if (!i_afifo_reset_n)
		begin
			started_n <= 1'b0;
			count_n <= 1'b0;
		end
		else
		begin
			if (started_p)
				started_n <= 1'b1;
			// Lane 1 / lane 3 alternation
			if (started_n)
				count_n <= ~count_n;
		end
	end

	// Arming edges see the old flag, so they never write
	assign lane_wr[0] = started_p && !count_p;
	assign lane_wr[1] = started_n && !count_n;
	assign lane_wr[2] = started_p && count_p;
	assign lane_wr[3] = started_n && count_n;

	////////////////////////////////////////////////////////////////////////////
	//
	// Lane FIFOs and word assembly
	//
	////////////////////////////////////////////////////////////////////////////

	// Pop all lanes together once each holds a sample
	assign o_data_valid = (lane_empty == '0);

	for (genvar gk = 0; gk < NLANES; gk++)
	begin : g_lane
		// Even lanes on rising DS, odd lanes on falling DS
		sd_ds_afifo #(
			.LGFIFO(LGFIFO),
			.payload_t(lane_t),
			.WRITE_ON_POSEDGE((gk % 2) == 0)
		) u_lane_fifo (
			.i_wclk(i_ds),
			.i_wr_reset_n(i_afifo_reset_n),
			.i_wr(lane_wr[gk]),
			.i_wr_data(i_dat),
			.o_wr_full(),
			.i_rclk(i_clk),
			.i_rd_reset_n(i_afifo_reset_n),
			.i_rd(o_data_valid),
			.o_rd_data(lane_data[gk]),
			.o_rd_empty(lane_empty[gk])
		);

		// Lane 0 lands in the top byte
		assign o_data_word[(NLANES-1-gk)*NUMIO +: NUMIO] = lane_data[gk];
	end

	// Falling sample always reaches the reader ahead of the next rising one
	a_lane_order: assert property (@(posedge i_clk) disable iff (!i_afifo_reset_n)
		!(lane_empty[1] && !lane_empty[2]));

endmodule

// File: src/sd_ds_frontend.sv
`timescale 1ns/10ps

// DS receive front end, data and command capture into the system clock
module sd_ds_frontend #(
	parameter int NUMIO = sd_ds_pkg::DEF_NUMIO,
	parameter int LGFIFO = sd_ds_pkg::DEF_LGFIFO
) (
	input  logic                                         i_clk,
	input  logic                                         i_afifo_reset_n,
	// Card strobe and pins
	input  logic                                         i_ds,
	input  logic                                         i_cmd_en,
	input  logic                                         i_cmd,
	input  logic [NUMIO-1:0]                             i_dat,
	// Data words
	output logic                                         o_data_valid,
	output logic [sd_ds_pkg::SAMPLES_PER_WORD*NUMIO-1:0] o_data_word,
	// Command pairs
	output logic                                         o_cmd_valid,
	output sd_ds_pkg::cmd_pair_t                         o_cmd_pair
);

	////////////////////////////////////////////////////////////////////////////
	//
	// DAT path, both DS edges
	//
	////////////////////////////////////////////////////////////////////////////

	sd_ds_data_capture #(
		.NUMIO(NUMIO),
		.LGFIFO(LGFIFO)
	) u_data_capture (
		.i_clk(i_clk),
		.i_afifo_reset_n(i_afifo_reset_n),
		.i_ds(i_ds),
		.i_dat(i_dat),
		.o_data_valid(o_data_valid),
		.o_data_word(o_data_word)
	);

	////////////////////////////////////////////////////////////////////////////
	//
	// CMD path, rising DS only
	//
	////////////////////////////////////////////////////////////////////////////

	sd_ds_cmd_capture #(
		.LGFIFO(LGFIFO)
	) u_cmd_capture (
		.i_clk(i_clk),
		.i_afifo_reset_n(i_afifo_reset_n),
		.i_ds(i_ds),
		.i_cmd_en(i_cmd_en),
		.i_cmd(i_cmd),
		.o_cmd_valid(o_cmd_valid),
		.o_cmd_pair(o_cmd_pair)
	);

endmodule

// File: src/sd_ds_pkg.sv
// Shared constants and types for the DS receive path

package sd_ds_pkg;

	////////////////////////////////////////////////////////////////////////////
	//
	// Lane and FIFO sizing
	//
	////////////////////////////////////////////////////////////////////////////

	// DAT pins, eMMC bus width
	parameter int DEF_NUMIO = 8;

	// Sixteen entries per lane FIFO
	parameter int DEF_LGFIFO = 4;

	// Two rising plus two falling DS samples per word
	parameter int SAMPLES_PER_WORD = 4;

	////////////////////////////////////////////////////////////////////////////
	//
	// Command items
	//
	////////////////////////////////////////////////////////////////////////////

	// CMD bits handed out per valid strobe
	parameter int CMD_PAIR_W = 2;

	// Earlier bit in the MSB
	typedef logic [CMD_PAIR_W-1:0] cmd_pair_t;

endpackage

// File: testbench/tb_sd_ds_frontend.sv
`timescale 1ns/10ps

// Drives DS, DAT and CMD streams into the front end and checks the words and pairs
module tb_sd_ds_frontend;

	localparam int NUMIO = 8;
	localparam int LGFIFO = 4;
	localparam int WORD_W = sd_ds_pkg::SAMPLES_PER_WORD * NUMIO;
	localparam int CLK_PERIOD = 8;
	localparam int LEAD = 2;
	localparam int MAX_PERIODS = 64;
	localparam int DRAIN_CYCLES = 16;
	// DS periods of all streams at four clock cycles each
	localparam int TOTAL_PERIODS = 16 + (LEAD + 17) + 3 * (LEAD + 25) + (LEAD + 48)
		+ (LEAD + 7) + (LEAD + 10) + (LEAD + 41);
	// Reset, pulses, enable clear and drain time on top
	localparam int STIM_CYCLES = 4 * TOTAL_PERIODS + 16 + 9 * 2 * DRAIN_CYCLES;

	logic                 i_clk;
	logic                 i_afifo_reset_n;
	logic                 i_ds;
	logic                 i_cmd_en;
	logic                 i_cmd;
	logic [NUMIO-1:0]     i_dat;
	logic                 o_data_valid;
	logic [WORD_W-1:0]    o_data_word;
	logic                 o_cmd_valid;
	sd_ds_pkg::cmd_pair_t o_cmd_pair;

	// Rising sample, falling sample and rising CMD bit per DS period
	logic [NUMIO-1:0]     rise_dat [0:MAX_PERIODS-1];
	logic [NUMIO-1:0]     fall_dat [0:MAX_PERIODS-1];
	logic                 rise_cmd [0:MAX_PERIODS-1];
	int                   n_periods;
	logic [31:0]          lfsr_state;
	logic [WORD_W-1:0]    exp_words [$];
	sd_ds_pkg::cmd_pair_t exp_pairs [$];

	sd_ds_frontend #(
		.NUMIO(NUMIO),
		.LGFIFO(LGFIFO)
	) dut0 (
		.i_clk(i_clk),
		.i_afifo_reset_n(i_afifo_reset_n),
		.i_ds(i_ds),
		.i_cmd_en(i_cmd_en),
		.i_cmd(i_cmd),
		.i_dat(i_dat),
		.o_data_valid(o_data_valid),
		.o_data_word(o_data_word),
		.o_cmd_valid(o_cmd_valid),
		.o_cmd_pair(o_cmd_pair)
	);

	// 125 MHz system clock
	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// Run length bound
	initial
	begin
		#(2 * STIM_CYCLES * CLK_PERIOD);
		fail_run("watchdog expired before the tests finished");
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	//
	// Stimulus helpers
	//
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One step per bit
	function automatic logic take_random_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	function automatic logic [NUMIO-1:0] random_byte();
		logic [NUMIO-1:0] value;
		value = '0;
		for (int k = 0; k < NUMIO; k++)
			value = {value[NUMIO-2:0], take_random_bit()};
		return value;
	endfunction

	// All lines high so neither path arms
	task automatic build_idle(input int periods);
		n_periods = periods;
		for (int p = 0; p < periods; p++)
		begin
			rise_dat[p] = '1;
			fall_dat[p] = '1;
			rise_cmd[p] = 1'b1;
		end
	endtask

	// Start period with DAT0 low, then two DS periods per word
	task automatic put_data_block(input int start, input int words);
		rise_dat[start] = random_byte();
		rise_dat[start][0] = 1'b0;
		fall_dat[start] = random_byte();
		for (int p = start + 1; p <= start + 2 * words; p++)
		begin
			rise_dat[p] = random_byte();
			fall_dat[p] = random_byte();
		end
	endtask

	// Low start bit followed by random bits
	task automatic put_cmd_bits(input int start, input int nbits);
		rise_cmd[start] = 1'b0;
		for (int p = start + 1; p < start + nbits; p++)
			rise_cmd[p] = take_random_bit();
	endtask

	////////////////////////////////////////////////////////////////////////////
	//
	// Reference model
	//
	////////////////////////////////////////////////////////////////////////////

	// Skips the start period and packs four samples a word with the first on top
	function automatic void pack_expected_words();
		logic [WORD_W-1:0] word;
		bit armed;
		int taken;
		word = '0;
		armed = 1'b0;
		taken = 0;
		for (int p = 0; p < n_periods; p++)
		begin
			if (armed)
			begin
				word = {word[WORD_W-2*NUMIO-1:0], rise_dat[p], fall_dat[p]};
				taken += 2;
				if (taken == sd_ds_pkg::SAMPLES_PER_WORD)
				begin
					exp_words.push_back(word);
					taken = 0;
				end
			end
			else if (!rise_dat[p][0])
				armed = 1'b1;
		end
	endfunction

	// Pairs from the start bit on with the earlier bit in the MSB and no odd tail
	function automatic void pair_expected_bits();
		sd_ds_pkg::cmd_pair_t pair;
		bit armed;
		int taken;
		pair = '0;
		armed = 1'b0;
		taken = 0;
		for (int p = 0; p < n_periods; p++)
		begin
			if (!rise_cmd[p])
				armed = 1'b1;
			if (armed)
			begin
				pair = {pair[sd_ds_pkg::CMD_PAIR_W-2:0], rise_cmd[p]};
				taken++;
				if (taken == sd_ds_pkg::CMD_PAIR_W)
				begin
					exp_pairs.push_back(pair);
					taken = 0;
				end
			end
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	//
	// Driving and checking
	//
	////////////////////////////////////////////////////////////////////////////

	// Pins change one cycle ahead of each DS edge and DS toggles every second cycle
	task automatic drive_stream();
		for (int p = 0; p < n_periods; p++)
		begin
			@(negedge i_clk);
			i_dat = rise_dat[p];
			i_cmd = rise_cmd[p];
			@(negedge i_clk);
			i_ds = 1'b1;
			@(negedge i_clk);
			i_dat = fall_dat[p];
			@(negedge i_clk);
			i_ds = 1'b0;
		end
	endtask

	task automatic run_stream();
		int waited;
		pack_expected_words();
		pair_expected_bits();
		drive_stream();
		// Every expected item out within the drain time and then quiet time for strays
		waited = 0;
		while ((exp_words.size() != 0 || exp_pairs.size() != 0) && waited < DRAIN_CYCLES)
		begin
			@(negedge i_clk);
			waited++;
		end
		assert (exp_words.size() == 0 && exp_pairs.size() == 0)
		else fail_run("expected items did not come out within the drain time");
		repeat (DRAIN_CYCLES) @(negedge i_clk);
	endtask

	// DS held low across the pulse
	task automatic apply_reset(input int cycles);
		@(negedge i_clk);
		i_afifo_reset_n = 1'b0;
		repeat (cycles) @(negedge i_clk);
		i_afifo_reset_n = 1'b1;
		@(negedge i_clk);
		assert (!o_data_valid && !o_cmd_valid)
		else fail_run("a valid strobe was high right after reset");
	endtask

	always @(posedge i_clk)
	begin : compare_outputs
		logic [WORD_W-1:0] want_word;
		sd_ds_pkg::cmd_pair_t want_pair;
		if (o_data_valid)
		begin
			assert (exp_words.size() != 0)
			else fail_run("o_data_valid pulsed with no data word expected");
			want_word = exp_words.pop_front();
			assert (o_data_word == want_word)
			else fail_run($sformatf("error at %0d ns: o_data_word expected %h, got %h",
				$time, want_word, o_data_word));
		end
		if (o_cmd_valid)
		begin
			assert (exp_pairs.size() != 0)
			else fail_run("o_cmd_valid pulsed with no command pair expected");
			want_pair = exp_pairs.pop_front();
			assert (o_cmd_pair == want_pair)
			else fail_run($sformatf("error at %0d ns: o_cmd_pair expected %b, got %b",
				$time, want_pair, o_cmd_pair));
		end
	end

	initial
	begin
		lfsr_state = 32'h4556986b;
		i_afifo_reset_n = 1'b0;
		i_ds = 1'b0;
		i_cmd_en = 1'b0;
		i_cmd = 1'b1;
		i_dat = '1;
		n_periods = 0;
		apply_reset(16);

		// DS running over idle lines for 64 cycles
		build_idle(16);
		run_stream();

		// One block of eight words
		apply_reset(4);
		build_idle(LEAD + 17);
		put_data_block(LEAD, 8);
		run_stream();

		// Three twelve-word blocks, start tracking cleared by each pulse
		for (int blk = 0; blk < 3; blk++)
		begin
			apply_reset(4);
			build_idle(LEAD + 25);
			put_data_block(LEAD, 12);
			run_stream();
		end

		// 48-bit response, 24 pairs
		apply_reset(4);
		build_idle(LEAD + 48);
		put_cmd_bits(LEAD, 48);
		run_stream();

		// Odd response and then a CMD enable pulse that drops the leftover bit
		apply_reset(4);
		build_idle(LEAD + 7);
		put_cmd_bits(LEAD, 7);
		run_stream();
		@(negedge i_clk);
		i_cmd_en = 1'b1;
		repeat (4) @(negedge i_clk);
		i_cmd_en = 1'b0;
		build_idle(LEAD + 10);
		put_cmd_bits(LEAD, 10);
		run_stream();

		// Both paths at once
		// Twenty words per lane wrap the 16-entry pointers
		apply_reset(4);
		build_idle(LEAD + 41);
		put_data_block(LEAD, 20);
		put_cmd_bits(LEAD + 3, 38);
		run_stream();

		$display("Simulation PASSED");
		$finish;
	end

endmodule
